// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= sources.f
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hw/msx_slot.sv
`timescale 1ns/1ns
`default_nettype none

module msx_slot (
	input wire clk42m,
	input wire reset,
	input wire dipsw0,				// 1 selects 0x98, 0 selects 0x88
	input wire p_slot_ioreq_n,
	input wire p_slot_rd_n,
	input wire p_slot_wr_n,
	input wire [15:0] p_slot_address,
	inout wire [7:0] p_slot_data,
	output logic p_slot_data_dir,		// 1 while we drive the data bus
	output logic p_slot_wait,
	output logic p_slot_int,
	output logic bus_valid,
	output vdp_pkg::bus_req_t bus_req,
	input wire bus_ready,
	input wire [7:0] bus_rdata,
	input wire bus_rdata_en,
	input wire int_n
);
	typedef enum logic [1:0] {
		st_idle,	// waiting for a claimed strobe
		st_req,		// bus_valid up
		st_wait,	// accepted, waiting for completion
		st_hold		// done, waiting for strobes to rise
	} slot_state_t;

	slot_state_t state;
	logic [1:0] ioreq_sr;	// two-flop syncs, [1] is the safe copy
	logic [1:0] rd_sr;
	logic [1:0] wr_sr;
	logic [7:0] base;
	logic claim;
	logic [7:0] rdata_q;	// byte put on the z80 bus

	// ------------------------------------------------------------
	// strobe sync and port decode
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (reset) begin
			ioreq_sr <= 2'b11;
			rd_sr <= 2'b11;
			wr_sr <= 2'b11;
		end else begin
			ioreq_sr <= {ioreq_sr[0], p_slot_ioreq_n};
			rd_sr <= {rd_sr[0], p_slot_rd_n};
			wr_sr <= {wr_sr[0], p_slot_wr_n};
		end
	end

	assign base = dipsw0 ? vdp_pkg::port_base_a : vdp_pkg::port_base_b;

	// a0 picks data/control, so only a7..a1 take part in the match
	assign claim = ~ioreq_sr[1] & (~rd_sr[1] | ~wr_sr[1]) &
		(p_slot_address[7:1] == base[7:1]);

	// ------------------------------------------------------------
	// cycle tracking
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (reset) begin
			state <= st_idle;
			bus_valid <= 1'b0;
			p_slot_wait <= 1'b0;
			p_slot_data_dir <= 1'b0;
		end else begin
			case (state)
			st_idle: begin
				if (claim) begin
					bus_valid <= 1'b1;
					p_slot_wait <= 1'b1;	// stall the z80 right away
					state <= st_req;
				end
			end
			st_req: begin
				if (bus_ready) begin		// accepted this cycle
					bus_valid <= 1'b0;
					state <= st_wait;
				end
			end
			st_wait: begin
				if (bus_req.write && bus_ready) begin
					p_slot_wait <= 1'b0;	// write retired
					state <= st_hold;
				end else if (!bus_req.write && bus_rdata_en) begin
					p_slot_wait <= 1'b0;
					p_slot_data_dir <= 1'b1;	// byte valid as wait drops
					state <= st_hold;
				end
			end
			default: begin
				if (rd_sr[1])
					p_slot_data_dir <= 1'b0;	// release on rd_n high
				if (ioreq_sr[1] && rd_sr[1] && wr_sr[1])
					state <= st_idle;
			end
			endcase
		end
	end

	// request payload, captured once the pins have settled
	always_ff @(posedge clk42m) begin
		if (state == st_idle && claim) begin
			bus_req.port_sel <= p_slot_address[0];
			bus_req.write <= ~wr_sr[1];
			bus_req.wdata <= p_slot_data;
			bus_req.ioreq <= 1'b1;
		end
		if (state == st_wait && bus_rdata_en)
			rdata_q <= bus_rdata;
	end

	assign p_slot_data = p_slot_data_dir ? rdata_q : 8'hzz;
	assign p_slot_int = ~int_n;		// slot int pin is active high here

endmodule

`default_nettype wire

// File: hw/msx_vdp_top.sv
`timescale 1ns/1ns
`default_nettype none

module msx_vdp_top (
	input wire clk42m,
	input wire reset,
	input wire dipsw0,			// port base select
	// msx slot
	input wire p_slot_ioreq_n,
	input wire p_slot_rd_n,
	input wire p_slot_wr_n,
	input wire [15:0] p_slot_address,
	inout wire [7:0] p_slot_data,
	output logic p_slot_data_dir,
	output logic p_slot_wait,
	output logic p_slot_int,
	// video
	output logic p_video_hs,
	output logic p_video_vs
);
	logic bus_valid;			// slot -> vdp
	vdp_pkg::bus_req_t bus_req;
	logic bus_ready;			// vdp -> slot, 0 busy
	logic [7:0] bus_rdata;
	logic bus_rdata_en;
	logic w_int_n;				// vdp -> slot
	logic w_vram_valid;			// vdp -> vram
	vdp_pkg::vram_req_t w_vram_req;
	logic [7:0] w_vram_rdata;		// vram -> vdp
	logic w_vram_rdata_en;
	logic w_frame_pulse;			// timing -> vdp

	// ------------------------------------------------------------
	// msx slot connector
	// ------------------------------------------------------------
	msx_slot u_msx_slot (
		.clk42m			( clk42m		),
		.reset			( reset			),
		.dipsw0			( dipsw0		),
		.p_slot_ioreq_n		( p_slot_ioreq_n	),
		.p_slot_rd_n		( p_slot_rd_n		),
		.p_slot_wr_n		( p_slot_wr_n		),
		.p_slot_address		( p_slot_address	),
		.p_slot_data		( p_slot_data		),
		.p_slot_data_dir	( p_slot_data_dir	),
		.p_slot_wait		( p_slot_wait		),
		.p_slot_int		( p_slot_int		),
		.bus_valid		( bus_valid		),
		.bus_req		( bus_req		),
		.bus_ready		( bus_ready		),
		.bus_rdata		( bus_rdata		),
		.bus_rdata_en		( bus_rdata_en		),
		.int_n			( w_int_n		)
	);

	// ------------------------------------------------------------
	// vdp port logic
	// ------------------------------------------------------------
	vdp_io u_vdp_io (
		.clk42m			( clk42m		),
		.reset			( reset			),
		.bus_valid		( bus_valid		),
		.bus_req		( bus_req		),
		.bus_ready		( bus_ready		),
		.bus_rdata		( bus_rdata		),
		.bus_rdata_en		( bus_rdata_en		),
		.vram_valid		( w_vram_valid		),
		.vram_req		( w_vram_req		),
		.vram_rdata		( w_vram_rdata		),
		.vram_rdata_en		( w_vram_rdata_en	),
		.frame_pulse		( w_frame_pulse		),
		.int_n			( w_int_n		)
	);

	// 16 KiB vram
	vdp_vram u_vdp_vram (
		.clk42m			( clk42m		),
		.vram_valid		( w_vram_valid		),
		.vram_req		( w_vram_req		),
		.vram_rdata		( w_vram_rdata		),
		.vram_rdata_en		( w_vram_rdata_en	)
	);

	// sync generator
	vdp_timing u_vdp_timing (
		.clk42m			( clk42m		),
		.reset			( reset			),
		.p_video_hs		( p_video_hs		),
		.p_video_vs		( p_video_vs		),
		.frame_pulse		( w_frame_pulse		)
	);

endmodule

`default_nettype wire

// File: hw/vdp_io.sv
`timescale 1ns/1ns
`default_nettype none

module vdp_io (
	input wire clk42m,
	input wire reset,
	input wire bus_valid,
	input wire vdp_pkg::bus_req_t bus_req,
	output logic bus_ready,
	output logic [7:0] bus_rdata,
	output logic bus_rdata_en,
	output logic vram_valid,
	output vdp_pkg::vram_req_t vram_req,
	input wire [7:0] vram_rdata,
	input wire vram_rdata_en,
	input wire frame_pulse,
	output logic int_n
);
	logic [7:0] regs [8];		// r#0..r#7
	logic latch_full;		// first control byte held
	logic [7:0] latch_byte;
	logic [vdp_pkg::vram_addr_w-1:0] addr_cnt;
	logic [7:0] rd_buf;		// read-ahead byte
	logic fetching;			// vram read in flight
	logic frame_flag;		// status bit 7

	vdp_pkg::ctrl_byte_u ctrl;
	logic [vdp_pkg::vram_addr_w-1:0] setup_addr;
	logic accept;
	logic ctrl_wr;
	logic ctrl_rd;
	logic data_wr;
	logic data_rd;
	logic second_byte;
	logic reg_wr;
	logic wr_setup;
	logic rd_setup;

	// ------------------------------------------------------------
	// request decode
	// ------------------------------------------------------------
	assign accept = bus_valid & bus_ready & bus_req.ioreq;
	assign ctrl_wr = accept & bus_req.port_sel & bus_req.write;
	assign ctrl_rd = accept & bus_req.port_sel & ~bus_req.write;	// status
	assign data_wr = accept & ~bus_req.port_sel & bus_req.write;
	assign data_rd = accept & ~bus_req.port_sel & ~bus_req.write;

	assign ctrl = bus_req.wdata;
	assign second_byte = ctrl_wr & latch_full;
	assign setup_addr = {ctrl.addr_view.addr_hi, latch_byte};

	// kind[1] set means register write whatever bit 6 holds
	assign reg_wr = second_byte & ctrl.reg_view.kind[1];
	assign wr_setup = second_byte & (ctrl.addr_view.kind == 2'b01);
	assign rd_setup = second_byte & (ctrl.addr_view.kind == 2'b00);

	// ------------------------------------------------------------
	// control state
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (reset) begin
			bus_ready <= 1'b1;
			bus_rdata_en <= 1'b0;
			vram_valid <= 1'b0;
			fetching <= 1'b0;
			latch_full <= 1'b0;
			frame_flag <= 1'b0;
			addr_cnt <= '0;
			regs <= '{default: 8'h00};
		end else begin
			bus_rdata_en <= ctrl_rd | data_rd;	// answer one cycle later
			vram_valid <= data_wr | data_rd | rd_setup;

			// write holds ready low 1 cycle, a fill holds it 2
			if (data_wr || data_rd || rd_setup)
				bus_ready <= 1'b0;
			else if (!fetching || vram_rdata_en)
				bus_ready <= 1'b1;

			if (data_rd || rd_setup)
				fetching <= 1'b1;
			else if (vram_rdata_en)
				fetching <= 1'b0;

			// status read throws away a half written pair
			if (ctrl_rd)
				latch_full <= 1'b0;
			else if (ctrl_wr)
				latch_full <= ~latch_full;

			if (reg_wr)
				regs[ctrl.reg_view.reg_num] <= latch_byte;

			// each fill reads at addr_cnt and steps past it
			if (wr_setup)
				addr_cnt <= setup_addr;
			else if (rd_setup)
				addr_cnt <= setup_addr + 14'd1;
			else if (data_wr || data_rd)
				addr_cnt <= addr_cnt + 14'd1;	// wraps at 16K

			if (frame_pulse)
				frame_flag <= 1'b1;		// set wins over a same-cycle read
			else if (ctrl_rd)
				frame_flag <= 1'b0;
		end
	end

	// ------------------------------------------------------------
	// data path
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (ctrl_wr && !latch_full)
			latch_byte <= bus_req.wdata;

		if (ctrl_rd)
			bus_rdata <= {frame_flag, 7'd0};	// no sprite status bits
		else if (data_rd)
			bus_rdata <= rd_buf;

		if (rd_setup)
			vram_req <= '{address: setup_addr, write: 1'b0, wdata: bus_req.wdata};
		else if (data_wr || data_rd)
			vram_req <= '{address: addr_cnt, write: data_wr, wdata: bus_req.wdata};

		if (vram_rdata_en)
			rd_buf <= vram_rdata;
	end

	// ie0 is r#1 bit 5
	assign int_n = ~(frame_flag & regs[1][5]);

endmodule

`default_nettype wire

// File: hw/vdp_pkg.sv
`default_nettype none

package vdp_pkg;

	// ------------------------------------------------------------
	// vram geometry
	// ------------------------------------------------------------
	localparam int vram_addr_w = 14;			// 16 KiB
	localparam int vram_depth = 16384;

	// i/o port bases picked by dipsw0
	localparam logic [7:0] port_base_a = 8'h98;	// msx default
	localparam logic [7:0] port_base_b = 8'h88;	// alternate slot

	// ------------------------------------------------------------
	// display timing
	// ------------------------------------------------------------
	localparam logic [8:0] dots_per_line = 9'd342;
	localparam logic [8:0] lines_per_frame = 9'd262;
	localparam logic [8:0] hsync_dots = 9'd26;		// hs low for dots 0..25
	localparam logic [8:0] vsync_lines = 9'd3;		// vs low for lines 0..2
	localparam logic [8:0] frame_flag_line = 9'd192;	// first vblank line

	// slot block -> vdp port logic
	typedef struct packed {
		logic port_sel;		// a0, 0 data port / 1 control port
		logic write;		// 1 out, 0 in
		logic [7:0] wdata;
		logic ioreq;		// claimed i/o cycle
	} bus_req_t;

	// vdp port logic -> vram
	typedef struct packed {
		logic [vram_addr_w-1:0] address;
		logic write;
		logic [7:0] wdata;
	} vram_req_t;

	// second control byte seen as a register write
	typedef struct packed {
		logic [1:0] kind;	// 2'b10 register write
		logic [2:0] spare;
		logic [2:0] reg_num;
	} ctrl_reg_t;

	// second control byte seen as an address setup
	typedef struct packed {
		logic [1:0] kind;	// 2'b01 write setup, 2'b00 read setup
		logic [5:0] addr_hi;
	} ctrl_addr_t;

	// same byte, decoded two ways
	typedef union packed {
		ctrl_reg_t reg_view;
		ctrl_addr_t addr_view;
	} ctrl_byte_u;

endpackage

`default_nettype wire

// File: hw/vdp_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vdp_timing (
	input wire clk42m,
	input wire reset,
	output logic p_video_hs,	// active low
	output logic p_video_vs,	// active low
	output logic frame_pulse	// start of vblank
);
	logic [8:0] dot_cnt;	// 0..341
	logic [8:0] line_cnt;	// 0..261
	logic line_end;
	logic frame_end;

	assign line_end = (dot_cnt == vdp_pkg::dots_per_line - 9'd1);
	assign frame_end = (line_cnt == vdp_pkg::lines_per_frame - 9'd1);

	// ------------------------------------------------------------
	// dot and line counters
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (reset) begin
			dot_cnt <= '0;
			line_cnt <= '0;
		end else if (line_end) begin
			dot_cnt <= '0;
			line_cnt <= frame_end ? 9'd0 : line_cnt + 9'd1;
		end else begin
			dot_cnt <= dot_cnt + 9'd1;
		end
	end

	// ------------------------------------------------------------
	// sync and frame pulse, one register stage behind the counters
	// ------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (reset) begin
			p_video_hs <= 1'b1;
			p_video_vs <= 1'b1;
			frame_pulse <= 1'b0;
		end else begin
			p_video_hs <= (dot_cnt >= vdp_pkg::hsync_dots);
			p_video_vs <= (line_cnt >= vdp_pkg::vsync_lines);	// whole lines
			frame_pulse <= (line_cnt == vdp_pkg::frame_flag_line) && (dot_cnt == 9'd0);
		end
	end

endmodule

`default_nettype wire

// File: hw/vdp_vram.sv
`timescale 1ns/1ns
`default_nettype none

module vdp_vram (
	input wire clk42m,
	input wire vram_valid,
	input wire vdp_pkg::vram_req_t vram_req,
	output logic [7:0] vram_rdata,
	output logic vram_rdata_en
);
	// ------------------------------------------------------------
	// 16K x 8 single port array
	// ------------------------------------------------------------
	logic [7:0] mem [vdp_pkg::vram_depth];

	always_ff @(posedge clk42m) begin
		if (vram_valid && vram_req.write)
			mem[vram_req.address] <= vram_req.wdata;
	end

	// registered read, data lands one cycle after the request
	always_ff @(posedge clk42m) begin
		if (vram_valid && !vram_req.write)
			vram_rdata <= mem[vram_req.address];
	end

	// read strobe follows the same pipeline stage
	always_ff @(posedge clk42m) begin
		vram_rdata_en <= vram_valid & ~vram_req.write;
	end

endmodule

`default_nettype wire

// File: sources.f
hw/vdp_pkg.sv
hw/msx_slot.sv
hw/vdp_io.sv
hw/vdp_vram.sv
hw/vdp_timing.sv
hw/msx_vdp_top.sv
test/tb_checker.sv
test/tb_top.sv

// File: test/tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
	input wire clk42m,
	input wire reset,
	input wire dipsw0,
	input wire wr_n,
	input wire [15:0] address,
	input wire [7:0] data,
	input wire data_dir,
	input wire slot_wait,
	input wire slot_int,
	input wire video_hs,
	input wire video_vs
);
	localparam int frame_cycles = 342 * 262;
	localparam int flag_cycle = 192 * 342 + 2;	// counter hit, pulse, then flag

	logic [7:0] vram [16384];	// model vram
	logic known [16384];		// written at least once
	logic [7:0] regs [8];
	logic [13:0] addr;
	logic [7:0] rd_buf;
	logic buf_known;
	logic latch;
	logic [7:0] latch_byte;
	logic flag;			// model frame flag
	logic wait_q;
	logic hs_q;
	logic vs_q;
	logic rd_hold;			// dut may drive the bus
	logic cyc_rd;
	logic [7:0] expect_rd;
	logic expect_known;
	int errors = 0;
	int cyc;
	int last_hs;
	int last_vs;
	int hs_periods = 0;
	int vs_periods = 0;

	always @(posedge clk42m) begin
		if (reset)
			cyc <= 0;
		else
			cyc <= cyc + 1;	// same count as the dut dot counter
	end

	task automatic fetch();
		rd_buf = vram[addr];
		buf_known = known[addr];
		addr = addr + 14'd1;
	endtask

	// ------------------------------------------------------------
	// model update at the start of each claimed cycle
	// ------------------------------------------------------------
	task automatic start_cycle();
		logic [7:0] base;
		base = dipsw0 ? vdp_pkg::port_base_a : vdp_pkg::port_base_b;
		rd_hold = 0;
		cyc_rd = 0;
		if (address[7:1] != base[7:1]) begin
			$display("ERR %0t: claimed port %h with dipsw0=%b", $time, address[7:0], dipsw0);
			errors++;
		end
		if (!wr_n && address[0]) begin
			if (!latch) begin
				latch_byte = data;	// first byte
				latch = 1;
			end else begin
				latch = 0;
				if (data[7])
					regs[data[2:0]] = latch_byte;
				else begin
					addr = {data[5:0], latch_byte};
					if (!data[6])
						fetch();	// read setup fills the buffer
				end
			end
		end else if (!wr_n) begin
			vram[addr] = data;
			known[addr] = 1;
			addr = addr + 14'd1;
		end else if (address[0]) begin
			expect_rd = {flag, 7'd0};	// status
			expect_known = 1;
			flag = 0;
			latch = 0;
			cyc_rd = 1;
		end else begin
			expect_rd = rd_buf;
			expect_known = buf_known;
			cyc_rd = 1;
			fetch();
		end
	endtask

	task automatic end_cycle();
		if (cyc_rd) begin
			rd_hold = 1;
			if (!data_dir) begin
				$display("read from port %h finished without driving the bus", address[7:0]);
				errors++;
			end else if (expect_known && data !== expect_rd) begin
				$display("ERR %0t: port %h read %h, expected %h", $time, address[7:0],
					data, expect_rd);
				errors++;
			end
		end
	endtask

	// sample away from the rising edge
	always @(negedge clk42m) begin
		if (reset) begin
			foreach (known[i])
				known[i] = 0;
			foreach (regs[i])
				regs[i] = 8'h00;
			addr = '0;
			buf_known = 0;
			latch = 0;
			flag = 0;
			wait_q = 0;
			hs_q = 1;
			vs_q = 1;
			rd_hold = 0;
			cyc_rd = 0;
			last_hs = -1;
			last_vs = -1;
		end else begin
			if (cyc % frame_cycles == flag_cycle)
				flag = 1;
			// ------------------------------------------------------------
			// sync periods
			// ------------------------------------------------------------
			if (hs_q && !video_hs) begin
				if (last_hs >= 0) begin
					if (cyc - last_hs != 342) begin
						$display("ERR %0t: hsync period %0d", $time, cyc - last_hs);
						errors++;
					end
					hs_periods++;
				end
				last_hs = cyc;
			end
			if (vs_q && !video_vs) begin
				if (last_vs >= 0) begin
					if (cyc - last_vs != frame_cycles) begin
						$display("ERR %0t: vsync period %0d", $time, cyc - last_vs);
						errors++;
					end
					vs_periods++;
				end
				last_vs = cyc;
			end
			if (slot_wait && !wait_q)
				start_cycle();
			if (!slot_wait && wait_q)
				end_cycle();
			// int is only defined outside a cycle in flight
			if (!slot_wait && slot_int !== (flag & regs[1][5])) begin
				$display("ERR %0t: int %b, flag %b ie %b", $time, slot_int, flag, regs[1][5]);
				errors++;
			end
			if (data_dir && !rd_hold) begin
				$display("ERR %0t: data bus driven outside a read", $time);
				errors++;
			end
			wait_q = slot_wait;
			hs_q = video_hs;
			vs_q = video_vs;
		end
	end

endmodule

`default_nettype wire

// File: test/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;
	logic clk42m = 1'b0;
	logic reset;
	logic dipsw0;
	logic ioreq_n;
	logic rd_n;
	logic wr_n;
	logic [15:0] address;
	logic [7:0] tb_data;
	logic drive;			// tb owns the data bus
	wire [7:0] slot_data;
	wire data_dir;
	wire slot_wait;
	wire slot_int;
	wire video_hs;
	wire video_vs;
	logic [31:0] lfsr;
	logic [7:0] base;
	int timeouts = 0;
	int err_mark = 0;

	assign slot_data = drive ? tb_data : 8'hzz;

	always #4 clk42m = ~clk42m;

	msx_vdp_top i_msx_vdp_top (
		.clk42m(clk42m), .reset(reset), .dipsw0(dipsw0),
		.p_slot_ioreq_n(ioreq_n), .p_slot_rd_n(rd_n), .p_slot_wr_n(wr_n),
		.p_slot_address(address), .p_slot_data(slot_data),
		.p_slot_data_dir(data_dir), .p_slot_wait(slot_wait), .p_slot_int(slot_int),
		.p_video_hs(video_hs), .p_video_vs(video_vs)
	);

	tb_checker u_checker (
		.clk42m(clk42m), .reset(reset), .dipsw0(dipsw0), .wr_n(wr_n),
		.address(address), .data(slot_data),
		.data_dir(data_dir), .slot_wait(slot_wait), .slot_int(slot_int),
		.video_hs(video_hs), .video_vs(video_vs)
	);

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return r;
	endfunction

	task automatic tick();
		@(posedge clk42m);
		#1;
	endtask

	// ------------------------------------------------------------
	// one z80 i/o cycle on the slot pins
	// ------------------------------------------------------------
	task automatic io_cycle(input logic [7:0] port, input logic wr, input logic [7:0] d,
			input logic claimed);
		int t;
		tick();
		address = {8'h00, port};
		tb_data = d;
		drive = wr;
		ioreq_n = 0;
		rd_n = wr;
		wr_n = ~wr;
		if (claimed) begin
			t = 0;
			while (!slot_wait && t < 20) begin
				tick();
				t++;
			end
			if (!slot_wait) begin
				$display("timeout: port %h never raised wait", port);
				timeouts++;
			end
			t = 0;
			while (slot_wait && t < 50) begin
				tick();
				t++;
			end
			if (slot_wait) begin
				$display("timeout: wait stuck high on port %h", port);
				timeouts++;
			end
		end else
			repeat (8) tick();	// must stay unclaimed
		ioreq_n = 1;
		rd_n = 1;
		wr_n = 1;
		drive = 0;
		t = 0;
		while (data_dir && t < 20) begin
			tick();
			t++;
		end
		if (data_dir) begin
			$display("timeout: data bus not released after port %h", port);
			timeouts++;
		end
		repeat (3) tick();	// let the slot fsm get back to idle
	endtask

	task automatic ctrl_write(input logic [7:0] d);
		io_cycle(base | 8'h01, 1, d, 1);
	endtask

	task automatic data_write(input logic [7:0] d);
		io_cycle(base, 1, d, 1);
	endtask

	task automatic data_read();
		io_cycle(base, 0, 8'h00, 1);
	endtask

	task automatic status_read();
		io_cycle(base | 8'h01, 0, 8'h00, 1);
	endtask

	task automatic set_addr(input logic [13:0] a, input logic wr);
		ctrl_write(a[7:0]);
		ctrl_write({1'b0, wr, a[13:8]});
	endtask

	task automatic reg_write(input logic [2:0] r, input logic [7:0] v);
		ctrl_write(v);
		ctrl_write({5'b10000, r});
	endtask

	task automatic wait_flag();
		int t;
		t = 0;
		while (!u_checker.flag && t < 200000) begin
			tick();
			t++;
		end
		if (!u_checker.flag) begin
			$display("timeout: frame flag never set");
			timeouts++;
		end
	endtask

	task automatic report(input string name);
		int now;
		now = u_checker.errors + timeouts;
		$display("test %s: %0d errors", name, now - err_mark);
		err_mark = now;
	endtask

	task automatic write_read_run(input logic [13:0] a, input int n);
		set_addr(a, 1);
		for (int i = 0; i < n; i++)
			data_write(rand_bits(8));
		set_addr(a, 0);
		for (int i = 0; i < n; i++)
			data_read();
	endtask

	initial begin
		logic [13:0] a;
		reset = 1;
		dipsw0 = 1;
		ioreq_n = 1;
		rd_n = 1;
		wr_n = 1;
		address = '0;
		tb_data = '0;
		drive = 0;
		lfsr = 32'hbdd3;
		base = vdp_pkg::port_base_a;
		repeat (4) tick();
		reset = 0;

		// vram runs, last one crosses the 16K wrap
		for (int i = 0; i < 6; i++)
			write_read_run(rand_bits(14), 1 + rand_bits(4));
		write_read_run(14'h3ffa, 10);
		report("vram write/read");

		a = rand_bits(14);
		set_addr(a, 1);
		for (int i = 0; i < 5; i++) begin
			reg_write(rand_bits(3) | 3'd2, rand_bits(8));	// keep r#1 for the irq test
			data_write(rand_bits(8));
		end
		set_addr(a, 0);
		for (int i = 0; i < 5; i++)
			data_read();
		report("register writes");

		a = rand_bits(14);
		write_read_run(a, 2);
		ctrl_write(rand_bits(8));	// orphan first byte
		status_read();
		set_addr(a, 0);
		data_read();
		data_read();
		report("latch reset");

		reg_write(3'd1, 8'h00);
		status_read();
		wait_flag();
		repeat (20) tick();
		status_read();
		status_read();
		reg_write(3'd1, 8'h20);
		wait_flag();
		repeat (20) tick();
		status_read();
		repeat (20) tick();
		report("frame flag and interrupt");

		for (int s = 0; s < 2; s++) begin
			dipsw0 = s[0];
			base = dipsw0 ? vdp_pkg::port_base_a : vdp_pkg::port_base_b;
			io_cycle(base ^ 8'h10, 1, 8'h55, 0);	// other base must be ignored
			io_cycle(base ^ 8'h11, 0, 8'h00, 0);
			write_read_run(rand_bits(14), 3);
		end
		report("port decode");

		a = 0;
		while (u_checker.vs_periods < 2 && a < 14'h3fff) begin
			repeat (20) tick();
			a++;
		end
		if (u_checker.vs_periods < 2 || u_checker.hs_periods == 0) begin
			$display("timeout: too few sync periods measured");
			timeouts++;
		end
		report("sync periods");

		$display("checks failed %0d, timeouts %0d", u_checker.errors, timeouts);
		if (u_checker.errors + timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
